// ==== Bender.yml ====
package:
  name: eth_loop

sources:
  - eth_loop_pkg.sv
  - mac_stream_if.sv
  - rx_frame_check.sv
  - port_crossover.sv
  - rx_error_monitor.sv
  - led_blinker.sv
  - eth_loop_top.sv
  - target: test
    files:
      - tb_eth_loop.sv

// ==== eth_loop_pkg.sv ====
package eth_loop_pkg;

    // --------------------
    // stream and counter types
    // --------------------

    // one byte of a MAC stream
    typedef logic [7:0] byte_t;

    // CRC-32 shift register
    typedef logic [31:0] crc_t;

    // per-port frame counters, wrap at the top
    typedef logic [15:0] frame_cnt_t;

    // port 0 and port 1 are crossed over to each other
    localparam int NUM_PORTS = 2;

    typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

    // --------------------
    // CRC-32 constants
    // --------------------

    // register start value
    localparam crc_t CRC_INIT = 32'hFFFF_FFFF;

    // 0x04C11DB7 bit reversed, for lsb-first shifting
    localparam crc_t CRC_POLY_REFLECTED = 32'hEDB8_8320;

    // register value left over once a correct FCS has been shifted in
    localparam crc_t CRC_RESIDUE = 32'hDEBB_20E3;

endpackage

// ==== eth_loop_top.sv ====
`timescale 1ns/10ps

module eth_loop_top #(
    parameter int MIN_FRAME_BYTES   = 64,
    parameter int BLINK_HALF_CYCLES = 10_000_000
) (
    input  logic                     clk20_g,
    input  logic                     rst_i,
    input  logic                     err_clear_i,
    input  eth_loop_pkg::byte_t      rx0_data_i,
    input  logic                     rx0_valid_i,
    input  logic                     rx0_sof_i,
    input  logic                     rx0_eof_i,
    input  eth_loop_pkg::byte_t      rx1_data_i,
    input  logic                     rx1_valid_i,
    input  logic                     rx1_sof_i,
    input  logic                     rx1_eof_i,
    output eth_loop_pkg::byte_t      tx0_data_o,
    output logic                     tx0_valid_o,
    output logic                     tx0_sof_o,
    output logic                     tx0_eof_o,
    output eth_loop_pkg::byte_t      tx1_data_o,
    output logic                     tx1_valid_o,
    output logic                     tx1_sof_o,
    output logic                     tx1_eof_o,
    output logic                     err_det_o,
    output logic                     err_sticky_o,
    output eth_loop_pkg::frame_cnt_t good_cnt0_o,
    output eth_loop_pkg::frame_cnt_t bad_cnt0_o,
    output eth_loop_pkg::frame_cnt_t good_cnt1_o,
    output eth_loop_pkg::frame_cnt_t bad_cnt1_o,
    output logic                     dbg_led_o
);

    import eth_loop_pkg::*;

    logic [NUM_PORTS-1:0]       fr_good;
    logic [NUM_PORTS-1:0]       fr_err;
    frame_cnt_t [NUM_PORTS-1:0] good_cnt;
    frame_cnt_t [NUM_PORTS-1:0] bad_cnt;

    mac_stream_if chk_stream0 ();
    mac_stream_if chk_stream1 ();
    mac_stream_if tx_stream0 ();
    mac_stream_if tx_stream1 ();

    // --------------------
    // receive checkers
    // --------------------

    rx_frame_check #(
        .MIN_FRAME_BYTES (MIN_FRAME_BYTES)
    ) chk0 (
        .clk20_g    (clk20_g),
        .rst_i      (rst_i),
        .rx_data_i  (rx0_data_i),
        .rx_valid_i (rx0_valid_i),
        .rx_sof_i   (rx0_sof_i),
        .rx_eof_i   (rx0_eof_i),
        .out_o      (chk_stream0.src),
        .fr_good_o  (fr_good[0]),
        .fr_err_o   (fr_err[0])
    );

    rx_frame_check #(
        .MIN_FRAME_BYTES (MIN_FRAME_BYTES)
    ) chk1 (
        .clk20_g    (clk20_g),
        .rst_i      (rst_i),
        .rx_data_i  (rx1_data_i),
        .rx_valid_i (rx1_valid_i),
        .rx_sof_i   (rx1_sof_i),
        .rx_eof_i   (rx1_eof_i),
        .out_o      (chk_stream1.src),
        .fr_good_o  (fr_good[1]),
        .fr_err_o   (fr_err[1])
    );

    // --------------------
    // crossover to tx
    // --------------------

    port_crossover xover (
        .clk20_g (clk20_g),
        .rst_i   (rst_i),
        .in0_i   (chk_stream0.snk),
        .in1_i   (chk_stream1.snk),
        .out0_o  (tx_stream0.src),
        .out1_o  (tx_stream1.src)
    );

    assign tx0_data_o  = tx_stream0.data;
    assign tx0_valid_o = tx_stream0.valid;
    assign tx0_sof_o   = tx_stream0.sof;
    assign tx0_eof_o   = tx_stream0.eof;
    assign tx1_data_o  = tx_stream1.data;
    assign tx1_valid_o = tx_stream1.valid;
    assign tx1_sof_o   = tx_stream1.sof;
    assign tx1_eof_o   = tx_stream1.eof;

    // --------------------
    // error monitor and LED
    // --------------------

    rx_error_monitor err_mon (
        .clk20_g      (clk20_g),
        .rst_i        (rst_i),
        .fr_good_i    (fr_good),
        .fr_err_i     (fr_err),
        .err_clear_i  (err_clear_i),
        .err_det_o    (err_det_o),
        .err_sticky_o (err_sticky_o),
        .good_cnt_o   (good_cnt),
        .bad_cnt_o    (bad_cnt)
    );

    assign good_cnt0_o = good_cnt[0];
    assign bad_cnt0_o  = bad_cnt[0];
    assign good_cnt1_o = good_cnt[1];
    assign bad_cnt1_o  = bad_cnt[1];

    led_blinker #(
        .BLINK_HALF_CYCLES (BLINK_HALF_CYCLES)
    ) heartbeat (
        .clk20_g (clk20_g),
        .rst_i   (rst_i),
        .led_o   (dbg_led_o)
    );

endmodule

// ==== filelist.f ====
eth_loop_pkg.sv
mac_stream_if.sv
rx_frame_check.sv
port_crossover.sv
rx_error_monitor.sv
led_blinker.sv
eth_loop_top.sv
tb_eth_loop.sv

// ==== led_blinker.sv ====
`timescale 1ns/10ps

module led_blinker #(
    parameter int BLINK_HALF_CYCLES = 10_000_000
) (
    input  logic clk20_g,
    input  logic rst_i,
    output logic led_o
);

    localparam int CNT_W = $clog2(BLINK_HALF_CYCLES + 1);

    typedef logic [CNT_W-1:0] tick_t;

    // one half period is RELOAD down to zero
    localparam tick_t RELOAD = tick_t'(BLINK_HALF_CYCLES - 1);

    tick_t cnt_q;

    // --------------------
    // half period timer
    // --------------------

    always_ff @(posedge clk20_g) begin
        if (rst_i) begin
            cnt_q <= RELOAD;
        end else if (cnt_q == '0) begin
            cnt_q <= RELOAD;
        end else begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // toggle on every reload
    always_ff @(posedge clk20_g) begin
        if (rst_i) begin
            led_o <= 1'b0;
        end else if (cnt_q == '0) begin
            led_o <= ~led_o;
        end
    end

endmodule

// ==== mac_stream_if.sv ====
`timescale 1ns/10ps

interface mac_stream_if;

    // byte stream of the MAC logic side
    eth_loop_pkg::byte_t data;
    logic                valid;

    // frame strobes, only meaningful with valid
    logic                sof;
    logic                eof;

    // driving side
    modport src (
        output data,
        output valid,
        output sof,
        output eof
    );

    // receiving side
    modport snk (
        input data,
        input valid,
        input sof,
        input eof
    );

endinterface

// ==== port_crossover.sv ====
`timescale 1ns/10ps

module port_crossover (
    input  logic      clk20_g,
    input  logic      rst_i,
    mac_stream_if.snk in0_i,
    mac_stream_if.snk in1_i,
    mac_stream_if.src out0_o,
    mac_stream_if.src out1_o
);

    // --------------------
    // data path
    // --------------------

    // port 1 goes out on port 0 and the other way round
    always_ff @(posedge clk20_g) begin
        out0_o.data <= in1_i.data;
        out1_o.data <= in0_i.data;
    end

    // --------------------
    // strobes
    // --------------------

    always_ff @(posedge clk20_g) begin
        if (rst_i) begin
            out0_o.valid <= 1'b0;
            out0_o.sof   <= 1'b0;
            out0_o.eof   <= 1'b0;
            out1_o.valid <= 1'b0;
            out1_o.sof   <= 1'b0;
            out1_o.eof   <= 1'b0;
        end else begin
            out0_o.valid <= in1_i.valid;
            out0_o.sof   <= in1_i.sof;
            out0_o.eof   <= in1_i.eof;
            out1_o.valid <= in0_i.valid;
            out1_o.sof   <= in0_i.sof;
            out1_o.eof   <= in0_i.eof;
        end
    end

endmodule

// ==== rx_error_monitor.sv ====
`timescale 1ns/10ps

module rx_error_monitor (
    input  logic                          clk20_g,
    input  logic                          rst_i,
    input  logic [1:0]                    fr_good_i,
    input  logic [1:0]                    fr_err_i,
    input  logic                          err_clear_i,
    output logic                          err_det_o,
    output logic                          err_sticky_o,
    output eth_loop_pkg::frame_cnt_t [1:0] good_cnt_o,
    output eth_loop_pkg::frame_cnt_t [1:0] bad_cnt_o
);

    import eth_loop_pkg::*;

    logic [NUM_PORTS-1:0] port_err_q;

    // --------------------
    // error tree
    // --------------------

    // stage one, per port
    always_ff @(posedge clk20_g) begin
        if (rst_i) begin
            port_err_q <= '0;
        end else begin
            port_err_q <= fr_err_i;
        end
    end

    // stage two, ports merged
    always_ff @(posedge clk20_g) begin
        if (rst_i) begin
            err_det_o <= 1'b0;
        end else begin
            err_det_o <= |port_err_q;
        end
    end

    // sticky flag rises together with err_det, set beats clear
    always_ff @(posedge clk20_g) begin
        if (rst_i) begin
            err_sticky_o <= 1'b0;
        end else if (|port_err_q) begin
            err_sticky_o <= 1'b1;
        end else if (err_clear_i) begin
            err_sticky_o <= 1'b0;
        end
    end

    // --------------------
    // frame counters
    // --------------------

    always_ff @(posedge clk20_g) begin
        if (rst_i) begin
            good_cnt_o <= '0;
            bad_cnt_o  <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (fr_good_i[port_idx_t'(p)]) begin
                    good_cnt_o[port_idx_t'(p)] <= good_cnt_o[port_idx_t'(p)] + 1'b1;
                end
                if (fr_err_i[port_idx_t'(p)]) begin
                    bad_cnt_o[port_idx_t'(p)] <= bad_cnt_o[port_idx_t'(p)] + 1'b1;
                end
            end
        end
    end

endmodule

// ==== rx_frame_check.sv ====
`timescale 1ns/10ps

module rx_frame_check #(
    parameter int MIN_FRAME_BYTES = 64
) (
    input  logic                clk20_g,
    input  logic                rst_i,
    input  eth_loop_pkg::byte_t rx_data_i,
    input  logic                rx_valid_i,
    input  logic                rx_sof_i,
    input  logic                rx_eof_i,
    mac_stream_if.src           out_o,
    output logic                fr_good_o,
    output logic                fr_err_o
);

    import eth_loop_pkg::*;

    // length counter only has to reach the runt limit
    localparam int LEN_W = $clog2(MIN_FRAME_BYTES + 1);

    typedef logic [LEN_W-1:0] len_t;

    localparam len_t LEN_MAX = len_t'(MIN_FRAME_BYTES);

    typedef enum logic {
        IDLE,
        IN_FRAME
    } state_t;

    state_t state_q;
    crc_t   crc_q;
    crc_t   crc_next;
    len_t   len_q;
    len_t   len_base;
    len_t   len_next;
    logic   bad_q;
    logic   bad_next;
    logic   frame_start;
    logic   stray;
    logic   abort;
    logic   eof_beat;
    logic   frame_bad;

    // bit-serial update, lsb of the byte first
    function automatic crc_t crc_byte(crc_t crc_in, byte_t data);
        crc_t crc;
        logic fb;
        crc = crc_in;
        for (int i = 0; i < 8; i++) begin
            fb  = crc[0] ^ data[i];
            crc = crc >> 1;
            if (fb) begin
                crc = crc ^ CRC_POLY_REFLECTED;
            end
        end
        return crc;
    endfunction

    // --------------------
    // frame tracking
    // --------------------

    // a byte while idle opens a frame too, with or without sof
    assign frame_start = rx_sof_i || (state_q == IDLE);
    assign stray       = !rx_sof_i && (state_q == IDLE);
    assign abort       = rx_valid_i && rx_sof_i && (state_q == IN_FRAME);
    assign eof_beat    = rx_valid_i && rx_eof_i;

    assign crc_next = crc_byte(frame_start ? CRC_INIT : crc_q, rx_data_i);
    assign len_base = frame_start ? '0 : len_q;
    assign len_next = (len_base == LEN_MAX) ? LEN_MAX : len_base + 1'b1;
    assign bad_next = frame_start ? stray : bad_q;

    // verdict on the last byte, FCS included
    assign frame_bad = bad_next || (crc_next != CRC_RESIDUE) || (len_next < LEN_MAX);

    always_ff @(posedge clk20_g) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else if (rx_valid_i) begin
            state_q <= rx_eof_i ? IDLE : IN_FRAME;
        end
    end

    always_ff @(posedge clk20_g) begin
        if (rx_valid_i) begin
            crc_q <= crc_next;
            len_q <= len_next;
            bad_q <= bad_next;
        end
    end

    // --------------------
    // checked stream
    // --------------------

    always_ff @(posedge clk20_g) begin
        out_o.data <= rx_data_i;
    end

    // strobes and verdict line up on the same output beat
    always_ff @(posedge clk20_g) begin
        if (rst_i) begin
            out_o.valid <= 1'b0;
            out_o.sof   <= 1'b0;
            out_o.eof   <= 1'b0;
            fr_good_o   <= 1'b0;
            fr_err_o    <= 1'b0;
        end else begin
            out_o.valid <= rx_valid_i;
            out_o.sof   <= rx_sof_i;
            out_o.eof   <= rx_eof_i;
            fr_err_o    <= abort || (eof_beat && frame_bad);
            fr_good_o   <= eof_beat && !frame_bad && !abort;
        end
    end

endmodule

// ==== tb_eth_loop.sv ====
`timescale 1ns/10ps

module tb_eth_loop;

    localparam int MIN_LEN = 16;
    localparam int BLINK   = 50;

    logic        clk20_g = 1'b0;
    logic        rst_i;
    logic        err_clear_i;
    logic [7:0]  rx0_data_i;
    logic        rx0_valid_i;
    logic        rx0_sof_i;
    logic        rx0_eof_i;
    logic [7:0]  rx1_data_i;
    logic        rx1_valid_i;
    logic        rx1_sof_i;
    logic        rx1_eof_i;
    logic [7:0]  tx0_data_o;
    logic        tx0_valid_o;
    logic        tx0_sof_o;
    logic        tx0_eof_o;
    logic [7:0]  tx1_data_o;
    logic        tx1_valid_o;
    logic        tx1_sof_o;
    logic        tx1_eof_o;
    logic        err_det_o;
    logic        err_sticky_o;
    logic [15:0] good_cnt0_o;
    logic [15:0] bad_cnt0_o;
    logic [15:0] good_cnt1_o;
    logic [15:0] bad_cnt1_o;
    logic        dbg_led_o;

    // beat layout: clear, good, bad, valid, sof, eof, data[7:0]
    logic [13:0] beat_q [2][$];
    logic [7:0]  exp_tx [2][$];
    logic [1:0]  exp_err;
    logic [15:0] exp_good0;
    logic [15:0] exp_bad0;
    logic [15:0] exp_good1;
    logic [15:0] exp_bad1;
    logic [31:0] lcg_state = 32'd7439;
    bit          gaps_on;
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          hb_cnt;

    eth_loop_top #(
        .MIN_FRAME_BYTES   (MIN_LEN),
        .BLINK_HALF_CYCLES (BLINK)
    ) eth_loop_top_i (.*);

    always #2 clk20_g = ~clk20_g;

    // --------------------
    // helpers
    // --------------------

    function automatic int unsigned lcg();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {16'h0, lcg_state[31:16]};
    endfunction

    // reflected CRC-32, one byte at a time
    function automatic logic [31:0] crc_step(logic [31:0] c, logic [7:0] b);
        logic [31:0] r;
        r = c ^ {24'h0, b};
        repeat (8) begin
            r = r[0] ? ((r >> 1) ^ 32'hEDB8_8320) : (r >> 1);
        end
        return r;
    endfunction

    task automatic log_failure(input string msg);
        $display("FAILED %0t: %s", $time, msg);
        errors = errors + 1;
    endtask

    task automatic add_idle(input int p, input int n, input bit clr);
        repeat (n) begin
            beat_q[p].push_back({clr, 13'h0});
        end
    endtask

    task automatic sync_ports();
        while (beat_q[0].size() != beat_q[1].size()) begin
            add_idle((beat_q[0].size() < beat_q[1].size()) ? 0 : 1, 1, 1'b0);
        end
    endtask

    task automatic add_frame(input int p, input int len, input bit corrupt,
                             input bit no_sof, input bit abort_prev);
        logic [7:0]  bytes [$];
        logic [31:0] crc;
        bit          bad;
        bit          first;
        bit          last;
        crc = 32'hFFFF_FFFF;
        for (int i = 0; i < len - 4; i++) begin
            bytes.push_back(8'(lcg()));
            crc = crc_step(crc, bytes[i]);
        end
        // FCS goes out lsb byte first
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            bytes.push_back(crc[8*i +: 8]);
        end
        if (corrupt) begin
            bytes[3] = bytes[3] ^ 8'h10;
        end
        bad = corrupt || no_sof || (len < MIN_LEN);
        if (gaps_on) begin
            add_idle(p, lcg() % 3, 1'b0);
        end
        for (int i = 0; i < len; i++) begin
            first = (i == 0);
            last  = (i == len - 1);
            if (gaps_on && !first && (lcg() % 5 == 0)) begin
                add_idle(p, 1, 1'b0);
            end
            beat_q[p].push_back({1'b0, last && !bad, (last && bad) || (first && abort_prev),
                                 1'b1, first && !no_sof, last, bytes[i]});
        end
    endtask

    // sof and bytes but no eof, cut short by the next sof
    task automatic add_partial(input int p, input int n);
        for (int i = 0; i < n; i++) begin
            beat_q[p].push_back({4'b0001, i == 0, 1'b0, 8'(lcg())});
        end
    endtask

    task automatic play_beats();
        logic [13:0] b0;
        logic [13:0] b1;
        while (beat_q[0].size() > 0 || beat_q[1].size() > 0) begin
            b0 = (beat_q[0].size() > 0) ? beat_q[0].pop_front() : 14'h0;
            b1 = (beat_q[1].size() > 0) ? beat_q[1].pop_front() : 14'h0;
            @(posedge clk20_g);
            #0.5;
            {err_clear_i, rx0_valid_i, rx0_sof_i, rx0_eof_i, rx0_data_i} = {b0[13], b0[10:0]};
            {rx1_valid_i, rx1_sof_i, rx1_eof_i, rx1_data_i} = b1[10:0];
            exp_err   = {b1[11], b0[11]};
            exp_good0 = exp_good0 + b0[12];
            exp_bad0  = exp_bad0 + b0[11];
            exp_good1 = exp_good1 + b1[12];
            exp_bad1  = exp_bad1 + b1[11];
            if (b0[10]) begin
                exp_tx[1].push_back(b0[7:0]);
            end
            if (b1[10]) begin
                exp_tx[0].push_back(b1[7:0]);
            end
        end
    endtask

    task automatic check_tx(input int p, input logic [7:0] data);
        logic [7:0] want;
        want = (exp_tx[p].size() > 0) ? exp_tx[p].pop_front() : 8'hxx;
        assert (want === data) else begin
            log_failure($sformatf("tx%0d byte %h, expected %h", p, data, want));
        end
    endtask

    // --------------------
    // checks
    // --------------------

    always @(posedge clk20_g) begin
        if (!rst_i && tx0_valid_o) begin
            check_tx(0, tx0_data_o);
        end
        if (!rst_i && tx1_valid_o) begin
            check_tx(1, tx1_data_o);
        end
    end

    always @(posedge clk20_g) begin
        if (rst_i) begin
            hb_cnt <= 0;
        end else begin
            hb_cnt <= hb_cnt + 1;
        end
    end

    assert property (@(posedge clk20_g) disable iff (rst_i)
        {tx1_valid_o, tx1_sof_o, tx1_eof_o} == $past({rx0_valid_i, rx0_sof_i, rx0_eof_i}, 2))
        else log_failure("port 0 strobes not on tx1 two cycles later");
    assert property (@(posedge clk20_g) disable iff (rst_i)
        {tx0_valid_o, tx0_sof_o, tx0_eof_o} == $past({rx1_valid_i, rx1_sof_i, rx1_eof_i}, 2))
        else log_failure("port 1 strobes not on tx0 two cycles later");
    assert property (@(posedge clk20_g) disable iff (rst_i)
        {good_cnt0_o, bad_cnt0_o} == $past({exp_good0, exp_bad0}, 2))
        else log_failure("port 0 frame counters wrong");
    assert property (@(posedge clk20_g) disable iff (rst_i)
        {good_cnt1_o, bad_cnt1_o} == $past({exp_good1, exp_bad1}, 2))
        else log_failure("port 1 frame counters wrong");
    assert property (@(posedge clk20_g) disable iff (rst_i)
        err_det_o == |$past(exp_err, 3))
        else log_failure("err_det_o not three cycles after the bad beat");
    assert property (@(posedge clk20_g) disable iff (rst_i) err_det_o |-> err_sticky_o)
        else log_failure("err_sticky_o low with err_det_o");
    assert property (@(posedge clk20_g) disable iff (rst_i)
        $past(err_sticky_o) && !$past(err_clear_i) |-> err_sticky_o)
        else log_failure("err_sticky_o dropped without clear");
    assert property (@(posedge clk20_g) disable iff (rst_i)
        $past(err_clear_i) && !err_det_o |-> !err_sticky_o)
        else log_failure("err_sticky_o not cleared");
    assert property (@(posedge clk20_g) $past(rst_i) |->
        !tx0_valid_o && !tx1_valid_o && !err_det_o && !err_sticky_o && !dbg_led_o &&
        {good_cnt0_o, bad_cnt0_o, good_cnt1_o, bad_cnt1_o} == 64'h0)
        else log_failure("outputs not in reset state");
    assert property (@(posedge clk20_g) disable iff (rst_i)
        dbg_led_o == ((hb_cnt / BLINK) % 2 == 1))
        else log_failure("dbg_led_o off its half period");

    always @(posedge clk20_g) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not end within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    // --------------------
    // stimulus
    // --------------------

    initial begin
        rst_i       = 1'b1;
        err_clear_i = 1'b0;
        {rx0_valid_i, rx0_sof_i, rx0_eof_i, rx0_data_i} = '0;
        {rx1_valid_i, rx1_sof_i, rx1_eof_i, rx1_data_i} = '0;
        {exp_err, exp_good0, exp_bad0, exp_good1, exp_bad1} = '0;
        gaps_on = 1'b1;
        for (int i = 0; i < 5; i++) begin
            add_frame(0, MIN_LEN + lcg() % 20, 1'b0, 1'b0, 1'b0);
            add_frame(1, MIN_LEN + lcg() % 20, 1'b0, 1'b0, 1'b0);
        end
        // bad FCS, runt, abort and stray bytes
        add_frame(0, 24, 1'b1, 1'b0, 1'b0);
        add_frame(1, 12, 1'b0, 1'b0, 1'b0);
        add_partial(0, 6);
        add_frame(0, 20, 1'b0, 1'b0, 1'b1);
        add_frame(1, 18, 1'b0, 1'b1, 1'b0);
        sync_ports();
        add_idle(0, 6, 1'b0);
        add_idle(0, 1, 1'b1);
        add_idle(0, 4, 1'b0);
        sync_ports();
        // same length, no gaps, so both end on one cycle
        gaps_on = 1'b0;
        add_frame(0, 20, 1'b0, 1'b0, 1'b0);
        add_frame(1, 20, 1'b1, 1'b0, 1'b0);
        add_idle(0, 10, 1'b0);
        sync_ports();
        cycle_limit = 30 + beat_q[0].size() + 200;
        repeat (10) @(posedge clk20_g);
        #0.5;
        rst_i = 1'b0;
        play_beats();
        // second reset while the sticky flag is set
        @(posedge clk20_g);
        #0.5;
        rst_i = 1'b1;
        {exp_good0, exp_bad0, exp_good1, exp_bad1} = '0;
        repeat (10) @(posedge clk20_g);
        #0.5;
        rst_i = 1'b0;
        repeat (5) @(posedge clk20_g);
        assert (exp_tx[0].size() == 0 && exp_tx[1].size() == 0) else begin
            log_failure("expected tx bytes never arrived");
        end
        $display("tb_eth_loop: %0d errors", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
